// File: all.f
mm_geom_pkg.sv
mm_fix_pkg.sv
mm_bram.sv
mm_dot_core.sv
mm_controller.sv
mm_top.sv
mm_top_sva.sv
tb_mm_top.sv

// File: Bender.yml
package:
  name: mm_top

sources:
  # Packages first, then the design
  - mm_geom_pkg.sv
  - mm_fix_pkg.sv
  - mm_bram.sv
  - mm_dot_core.sv
  - mm_controller.sv
  - mm_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - mm_top_sva.sv
      - tb_mm_top.sv

// File: tb_mm_top.sv
// ------------------------------------------------
// Testbench for the matrix-multiply top level
// Case table, reference model, result checks
// ------------------------------------------------
`timescale 1ns/10ps

module tb_mm_top;
    import mm_geom_pkg::*;
    import mm_fix_pkg::*;

    localparam int WIDTH       = DEF_WIDTH;
    localparam int FRAC        = DEF_FRAC_WIDTH;
    localparam int CHUNK       = DEF_CHUNK_SIZE;
    localparam int INNER       = DEF_INNER_DIMENSION;
    localparam int I_OUTER     = DEF_I_OUTER_DIMENSION;
    localparam int W_OUTER     = DEF_W_OUTER_DIMENSION;
    localparam int K_CHUNKS    = INNER / CHUNK;
    localparam int WORD_W      = WIDTH * CHUNK;
    localparam int BE_W        = WORD_W / BYTE_WIDTH;
    localparam int IN_DEPTH    = I_OUTER * K_CHUNKS;
    localparam int WB_DEPTH    = W_OUTER * K_CHUNKS;
    localparam int IN_AW       = addr_bits(IN_DEPTH);
    localparam int WB_AW       = addr_bits(WB_DEPTH);
    localparam int N_RES       = I_OUTER * W_OUTER;   // Results per run
    localparam int TIMEOUT     = 200;                 // Cycles per wait loop
    localparam int N_CASES     = 4;
    localparam int PAT_ONES    = 0;
    localparam int PAT_RANDOM  = 1;
    localparam int PAT_EXTREME = 2;
    localparam int PAT_PATCH   = 3;                   // Random, then byte-masked writes

    logic              clk;
    logic              rst_n;
    logic              in_ena, wb_ena;
    logic [BE_W-1:0]   in_wea, wb_wea;
    logic [IN_AW-1:0]  in_addra;
    logic [WB_AW-1:0]  wb_addra;
    logic [WORD_W-1:0] in_dina, wb_dina;
    logic              start;
    logic [WIDTH-1:0]  out_data;
    logic              out_valid, top_ready, done;

    logic [WORD_W-1:0] in_model [IN_DEPTH];  // Expected memory contents
    logic [WORD_W-1:0] wb_model [WB_DEPTH];
    int                exp_c [N_RES];        // Row-major expected C
    logic [31:0]       rng_state;
    int                errors;
    int                checks;
    string             case_name [N_CASES];
    int                case_pat  [N_CASES];
    int                case_runs [N_CASES];

    mm_top #(
        .WIDTH(WIDTH), .FRAC_WIDTH(FRAC), .CHUNK_SIZE(CHUNK), .INNER_DIMENSION(INNER),
        .I_OUTER_DIMENSION(I_OUTER), .W_OUTER_DIMENSION(W_OUTER)
    ) i_dut (
        .clk(clk), .rst_n(rst_n),
        .in_ena(in_ena), .in_wea(in_wea), .in_addra(in_addra), .in_dina(in_dina),
        .wb_ena(wb_ena), .wb_wea(wb_wea), .wb_addra(wb_addra), .wb_dina(wb_dina),
        .start(start), .out_data(out_data), .out_valid(out_valid),
        .top_ready(top_ready), .done(done)
    );

    always #10 clk = ~clk;  // 20 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Signed element e of a chunk word
    function automatic int elem_of(input logic [WORD_W-1:0] word, input int e);
        return int'($signed(word[e*WIDTH +: WIDTH]));
    endfunction

    // C[r][c] = sum over k of I[r][k] * W[c][k], shifted and clamped
    function automatic int expected_elem(input int r, input int c);
        longint acc;
        longint shifted;
        acc = 0;
        for (int k = 0; k < INNER; k++) begin
            acc += longint'(elem_of(in_model[r*K_CHUNKS + k/CHUNK], k % CHUNK))
                 * longint'(elem_of(wb_model[c*K_CHUNKS + k/CHUNK], k % CHUNK));
        end
        shifted = acc >>> FRAC;
        if (shifted > longint'(2**(WIDTH-1) - 1)) return 2**(WIDTH-1) - 1;
        if (shifted < -longint'(2**(WIDTH-1))) return -(2**(WIDTH-1));
        return int'(shifted);
    endfunction

    task automatic report_mismatch(input string what, input int expected, input int actual);
        errors++;
        $display("CHECK FAILED %s: expected %0d, actual %0d", what, expected, actual);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR %s", msg);
    endtask

    task automatic fill_word(input int pat, input bit is_wb, input int addr,
                             output logic [WORD_W-1:0] word);
        logic [WIDTH-1:0] v;
        for (int e = 0; e < CHUNK; e++) begin
            rng_state = xorshift32(rng_state);
            case (pat)
                PAT_ONES:    v = WIDTH'(1 << FRAC);                 // 1.0
                PAT_EXTREME: v = (is_wb && addr >= K_CHUNKS)        // W row 0 max, others min
                                 ? {1'b1, {(WIDTH-1){1'b0}}} : {1'b0, {(WIDTH-1){1'b1}}};
                default:     v = {{(WIDTH-10){rng_state[9]}}, rng_state[9:0]}; // Small signed
            endcase
            word[e*WIDTH +: WIDTH] = v;
        end
    endtask

    // One write on a port, model merges the enabled bytes
    task automatic write_word(input bit is_wb, input int addr, input logic [WORD_W-1:0] data,
                              input logic [BE_W-1:0] be);
        @(negedge clk);
        if (is_wb) begin
            wb_ena   = 1'b1;
            wb_wea   = be;
            wb_addra = WB_AW'(addr);
            wb_dina  = data;
        end else begin
            in_ena   = 1'b1;
            in_wea   = be;
            in_addra = IN_AW'(addr);
            in_dina  = data;
        end
        @(negedge clk);
        in_ena = 1'b0;
        wb_ena = 1'b0;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b] && is_wb) wb_model[addr][b*BYTE_WIDTH +: BYTE_WIDTH] =
                data[b*BYTE_WIDTH +: BYTE_WIDTH];
            if (be[b] && !is_wb) in_model[addr][b*BYTE_WIDTH +: BYTE_WIDTH] =
                data[b*BYTE_WIDTH +: BYTE_WIDTH];
        end
    endtask

    task automatic load_memories(input int pat);
        logic [WORD_W-1:0] word;
        for (int a = 0; a < IN_DEPTH; a++) begin
            fill_word(pat, 1'b0, a, word);
            write_word(1'b0, a, word, '1);
        end
        for (int a = 0; a < WB_DEPTH; a++) begin
            fill_word(pat, 1'b1, a, word);
            write_word(1'b1, a, word, '1);
        end
        if (pat == PAT_PATCH) begin
            rng_state = xorshift32(rng_state);
            word = {rng_state, ~rng_state};
            write_word(1'b0, IN_DEPTH/2, word, 8'b0011_0101);  // Scattered bytes
            rng_state = xorshift32(rng_state);
            word = {~rng_state, rng_state};
            write_word(1'b1, WB_DEPTH-1, word, 8'b1100_0010);
        end
        for (int r = 0; r < I_OUTER; r++) begin
            for (int c = 0; c < W_OUTER; c++) exp_c[r*W_OUTER + c] = expected_elem(r, c);
        end
    endtask

    // One start pulse, collect and check all results of the run
    task automatic run_matrix(input string name);
        int    got;
        int    cyc;
        int    last_cyc;
        string tag;
        got      = 0;
        cyc      = -1;                          // Becomes 0 just after the start edge
        last_cyc = 0;
        @(negedge clk);
        start = 1'b1;
        while (got < N_RES && cyc < TIMEOUT) begin
            @(negedge clk);
            start = 1'b0;
            cyc++;
            checks++;
            if (cyc == 0 && (done || top_ready))
                report_error({name, ": start did not clear done and top_ready"});
            if (out_valid) begin
                tag = $sformatf("%s C[%0d][%0d]", name, got / W_OUTER, got % W_OUTER);
                checks++;
                if ($signed(out_data) != exp_c[got])
                    report_mismatch(tag, exp_c[got], $signed(out_data));
                if (got == 0 && cyc != K_CHUNKS + 3)
                    report_mismatch({tag, " latency"}, K_CHUNKS + 3, cyc);
                if (got > 0 && cyc - last_cyc != K_CHUNKS)
                    report_mismatch({tag, " spacing"}, K_CHUNKS, cyc - last_cyc);
                if (top_ready != (got > 0))
                    report_mismatch({tag, " top_ready"}, int'(got > 0), int'(top_ready));
                last_cyc = cyc;
                got++;
                if (got == 2) start = 1'b1;     // Mid-run start, must be ignored
            end
        end
        start = 1'b0;
        if (got < N_RES)
            report_error($sformatf("%s: timed out after %0d of %0d results", name, got, N_RES));
        @(negedge clk);
        checks++;
        if (!done) report_error({name, ": done not high the cycle after the final result"});
        for (int i = 0; i < 2*K_CHUNKS + 6; i++) begin
            @(negedge clk);
            if (out_valid) report_error({name, ": extra result after the final one"});
            if (!done || !top_ready) report_error({name, ": done or top_ready dropped"});
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_ena    = 1'b0;
        in_wea    = '0;
        in_addra  = '0;
        in_dina   = '0;
        wb_ena    = 1'b0;
        wb_wea    = '0;
        wb_addra  = '0;
        wb_dina   = '0;
        start     = 1'b0;
        rng_state = 32'hc1d8;
        errors    = 0;
        checks    = 0;
        // Name, fill pattern, runs
        case_name[0] = "ones";
        case_pat[0]  = PAT_ONES;
        case_runs[0] = 2;
        case_name[1] = "random";
        case_pat[1]  = PAT_RANDOM;
        case_runs[1] = 1;
        case_name[2] = "extreme";
        case_pat[2]  = PAT_EXTREME;
        case_runs[2] = 2;
        case_name[3] = "byte_patch";
        case_pat[3]  = PAT_PATCH;
        case_runs[3] = 1;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        checks++;
        if (out_valid || done || top_ready) report_error("outputs not low after reset");
        for (int t = 0; t < N_CASES; t++) begin
            load_memories(case_pat[t]);
            for (int run = 0; run < case_runs[t]; run++) begin
                run_matrix($sformatf("%s run %0d", case_name[t], run));
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: mm_top_sva.sv
// ------------------------------------------------
// Bound checks on controller state and output timing
// ------------------------------------------------
`timescale 1ns/10ps

module mm_top_sva (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done,
    input logic out_valid,
    input logic in_ena,
    input logic wb_ena
);

    // No result once the run has finished
    a_no_valid_when_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_valid && done))
        else $error("out_valid pulsed while done was high");

    a_done_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(done && busy))
        else $error("done and busy high together");

    // Host keeps off the memories during a run
    a_no_write_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> (!in_ena && !wb_ena))
        else $error("memory write while a run is busy");

endmodule

bind mm_top mm_top_sva i_sva (
    .clk(clk), .rst_n(rst_n), .busy(i_ctrl.busy), .done(done),
    .out_valid(out_valid), .in_ena(in_ena), .wb_ena(wb_ena)
);

// File: mm_top.sv
// ------------------------------------------------
// Matrix-multiply top level, C = I * W^T
// Operand memories, dot-product core, controller
// ------------------------------------------------
`timescale 1ns/10ps

module mm_top #(
    parameter int  WIDTH             = mm_fix_pkg::DEF_WIDTH,
    parameter int  FRAC_WIDTH        = mm_fix_pkg::DEF_FRAC_WIDTH,
    parameter int  CHUNK_SIZE        = mm_geom_pkg::DEF_CHUNK_SIZE,
    parameter int  INNER_DIMENSION   = mm_geom_pkg::DEF_INNER_DIMENSION,
    parameter int  I_OUTER_DIMENSION = mm_geom_pkg::DEF_I_OUTER_DIMENSION,
    parameter int  W_OUTER_DIMENSION = mm_geom_pkg::DEF_W_OUTER_DIMENSION,
    localparam int K_CHUNKS = INNER_DIMENSION / CHUNK_SIZE,
    localparam int WORD_W   = WIDTH * CHUNK_SIZE,           // One chunk per word
    localparam int BE_W     = WORD_W / mm_geom_pkg::BYTE_WIDTH,
    localparam int IN_DEPTH = I_OUTER_DIMENSION * K_CHUNKS,
    localparam int WB_DEPTH = W_OUTER_DIMENSION * K_CHUNKS,
    localparam int IN_AW    = mm_geom_pkg::addr_bits(IN_DEPTH),
    localparam int WB_AW    = mm_geom_pkg::addr_bits(WB_DEPTH)
) (
    input  logic              clk,
    input  logic              rst_n,
    // Input matrix write port
    input  logic              in_ena,
    input  logic [BE_W-1:0]   in_wea,
    input  logic [IN_AW-1:0]  in_addra,
    input  logic [WORD_W-1:0] in_dina,
    // Weight matrix write port
    input  logic              wb_ena,
    input  logic [BE_W-1:0]   wb_wea,
    input  logic [WB_AW-1:0]  wb_addra,
    input  logic [WORD_W-1:0] wb_dina,
    input  logic              start,
    output logic [WIDTH-1:0]  out_data,  // One C element per out_valid
    output logic              out_valid,
    output logic              top_ready,
    output logic              done
);

    logic              in_rd_en, wb_rd_en;
    logic [IN_AW-1:0]  in_rd_addr;
    logic [WB_AW-1:0]  wb_rd_addr;
    logic [WORD_W-1:0] in_rd_data, wb_rd_data;
    logic              rd_valid, rd_last, rd_final;
    logic              res_final;            // Back to controller for done

    mm_bram #(.WORD_WIDTH(WORD_W), .DEPTH(IN_DEPTH)) i_in_mem (
        .clk(clk), .rst_n(rst_n),
        .wr_en(in_ena), .wr_be(in_wea), .wr_addr(in_addra), .wr_data(in_dina),
        .rd_en(in_rd_en), .rd_addr(in_rd_addr), .rd_data(in_rd_data)
    );

    mm_bram #(.WORD_WIDTH(WORD_W), .DEPTH(WB_DEPTH)) i_wb_mem (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wb_ena), .wr_be(wb_wea), .wr_addr(wb_addra), .wr_data(wb_dina),
        .rd_en(wb_rd_en), .rd_addr(wb_rd_addr), .rd_data(wb_rd_data)
    );

    mm_dot_core #(.WIDTH(WIDTH), .FRAC_WIDTH(FRAC_WIDTH), .CHUNK_SIZE(CHUNK_SIZE)) i_core (
        .clk(clk), .rst_n(rst_n),
        .in_valid(rd_valid), .in_last(rd_last), .in_final(rd_final),
        .a_chunk(in_rd_data), .b_chunk(wb_rd_data),   // I row against W row
        .res_data(out_data), .res_valid(out_valid), .res_final(res_final)
    );

    mm_controller #(
        .CHUNK_SIZE(CHUNK_SIZE), .INNER_DIMENSION(INNER_DIMENSION),
        .I_OUTER_DIMENSION(I_OUTER_DIMENSION), .W_OUTER_DIMENSION(W_OUTER_DIMENSION)
    ) i_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start),
        .in_rd_en(in_rd_en), .in_rd_addr(in_rd_addr),
        .wb_rd_en(wb_rd_en), .wb_rd_addr(wb_rd_addr),
        .rd_valid(rd_valid), .rd_last(rd_last), .rd_final(rd_final),
        .res_valid(out_valid), .res_final(res_final),
        .top_ready(top_ready), .done(done)
    );

endmodule

// File: mm_controller.sv
// ------------------------------------------------
// Matrix-multiply controller
// Start/done, read sequencing over row, col, chunk
// ------------------------------------------------
`timescale 1ns/10ps

module mm_controller #(
    parameter int  CHUNK_SIZE        = mm_geom_pkg::DEF_CHUNK_SIZE,
    parameter int  INNER_DIMENSION   = mm_geom_pkg::DEF_INNER_DIMENSION,
    parameter int  I_OUTER_DIMENSION = mm_geom_pkg::DEF_I_OUTER_DIMENSION,
    parameter int  W_OUTER_DIMENSION = mm_geom_pkg::DEF_W_OUTER_DIMENSION,
    localparam int K_CHUNKS          = INNER_DIMENSION / CHUNK_SIZE,
    localparam int IN_AW = mm_geom_pkg::addr_bits(I_OUTER_DIMENSION * K_CHUNKS),
    localparam int WB_AW = mm_geom_pkg::addr_bits(W_OUTER_DIMENSION * K_CHUNKS)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,      // One-cycle pulse
    output logic             in_rd_en,
    output logic [IN_AW-1:0] in_rd_addr,
    output logic             wb_rd_en,
    output logic [WB_AW-1:0] wb_rd_addr,
    output logic             rd_valid,   // Aligned with memory read data
    output logic             rd_last,
    output logic             rd_final,
    input  logic             res_valid,
    input  logic             res_final,
    output logic             top_ready,
    output logic             done
);
    import mm_geom_pkg::*;

    localparam int CHUNK_W = addr_bits(K_CHUNKS);
    localparam int COL_W   = addr_bits(W_OUTER_DIMENSION);
    localparam int ROW_W   = addr_bits(I_OUTER_DIMENSION);

    logic               busy;                  // Run in progress, until final result
    logic [CHUNK_W-1:0] chunk_cnt;
    logic [COL_W-1:0]   col_cnt;               // Row of W, column of C
    logic [ROW_W-1:0]   row_cnt;               // Row of I and of C
    logic               chunk_end, col_end, row_end;
    logic               issue_last, issue_final;

    assign chunk_end   = (chunk_cnt == CHUNK_W'(K_CHUNKS - 1));
    assign col_end     = (col_cnt == COL_W'(W_OUTER_DIMENSION - 1));
    assign row_end     = (row_cnt == ROW_W'(I_OUTER_DIMENSION - 1));
    assign issue_last  = in_rd_en && chunk_end;
    assign issue_final = issue_last && col_end && row_end;

    // Both memories are read in lockstep
    assign wb_rd_en = in_rd_en;

    // Word address is row * K_CHUNKS + chunk
    always_comb begin
        in_rd_addr = IN_AW'(row_cnt) * IN_AW'(K_CHUNKS) + IN_AW'(chunk_cnt);
        wb_rd_addr = WB_AW'(col_cnt) * WB_AW'(K_CHUNKS) + WB_AW'(chunk_cnt);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            in_rd_en  <= 1'b0;
            chunk_cnt <= '0;
            col_cnt   <= '0;
            row_cnt   <= '0;
            top_ready <= 1'b0;
            done      <= 1'b0;
        end else if (start && !busy) begin   // Start while busy is ignored
            busy      <= 1'b1;
            in_rd_en  <= 1'b1;               // First read on the next cycle
            chunk_cnt <= '0;
            col_cnt   <= '0;
            row_cnt   <= '0;
            top_ready <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (in_rd_en) begin
                // Chunk innermost, then column, then row
                if (chunk_end) begin
                    chunk_cnt <= '0;
                    if (col_end) begin
                        col_cnt <= '0;
                        row_cnt <= row_end ? '0 : row_cnt + 1'b1;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end else begin
                    chunk_cnt <= chunk_cnt + 1'b1;
                end
                if (issue_final) in_rd_en <= 1'b0; // Whole matrix issued
            end
            if (res_valid) top_ready <= 1'b1;
            if (res_valid && res_final) begin
                done <= 1'b1;
                busy <= 1'b0;
            end
        end
    end

    // Flags follow read data by the memory latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            rd_last  <= 1'b0;
            rd_final <= 1'b0;
        end else begin
            rd_valid <= in_rd_en;
            rd_last  <= issue_last;
            rd_final <= issue_final;
        end
    end

endmodule

// File: mm_dot_core.sv
// ------------------------------------------------
// Chunk dot-product core
// Multiply-sum, accumulate, shift and saturate
// ------------------------------------------------
`timescale 1ns/10ps

module mm_dot_core #(
    parameter int WIDTH      = mm_fix_pkg::DEF_WIDTH,
    parameter int FRAC_WIDTH = mm_fix_pkg::DEF_FRAC_WIDTH,
    parameter int CHUNK_SIZE = mm_geom_pkg::DEF_CHUNK_SIZE
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,  // Chunk pair present
    input  logic                        in_last,   // Last chunk of an element
    input  logic                        in_final,  // Last chunk of the matrix
    input  logic [WIDTH*CHUNK_SIZE-1:0] a_chunk,   // Element e at bits [e*WIDTH +: WIDTH]
    input  logic [WIDTH*CHUNK_SIZE-1:0] b_chunk,
    output logic [WIDTH-1:0]            res_data,
    output logic                        res_valid,
    output logic                        res_final
);
    import mm_fix_pkg::*;

    localparam int SUM_W = 2*WIDTH + $clog2(CHUNK_SIZE) + 1; // Chunk sum width with headroom
    localparam int ACC_W = 2*WIDTH + ACC_GUARD;

    // Saturation bounds sign extended to the accumulator width
    localparam logic signed [ACC_W-1:0] SAT_MAX = {{(ACC_W-WIDTH+1){1'b0}}, {(WIDTH-1){1'b1}}};
    localparam logic signed [ACC_W-1:0] SAT_MIN = {{(ACC_W-WIDTH+1){1'b1}}, {(WIDTH-1){1'b0}}};

    logic signed [SUM_W-1:0] prod_sum;  // Comb products of the chunk
    logic signed [SUM_W-1:0] s1_sum;    // Stage 1 register
    logic                    s1_valid, s1_last, s1_final;
    logic signed [ACC_W-1:0] acc, acc_next;
    logic                    acc_clear; // Next chunk starts a new element
    logic                    acc_last, acc_final;

    // Arithmetic shift back to Q format and clamp
    function automatic logic [WIDTH-1:0] saturate(input logic signed [ACC_W-1:0] value);
        logic signed [ACC_W-1:0] shifted;
        shifted = value >>> FRAC_WIDTH;
        if (shifted > SAT_MAX) return SAT_MAX[WIDTH-1:0];
        if (shifted < SAT_MIN) return SAT_MIN[WIDTH-1:0];
        return shifted[WIDTH-1:0];
    endfunction

    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < CHUNK_SIZE; i++) begin
            prod_sum = prod_sum + $signed(a_chunk[i*WIDTH +: WIDTH])
                                * $signed(b_chunk[i*WIDTH +: WIDTH]);
        end
    end

    // Stage 1 registers the chunk sum with its flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
            s1_final <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            s1_last  <= in_valid && in_last;
            s1_final <= in_valid && in_final;
        end
    end

    always_ff @(posedge clk) begin
        s1_sum <= prod_sum; // Chunk sum beside its flags
    end

    // Stage 2 accumulates and a last chunk restarts the next element
    always_comb begin
        acc_next = s1_sum;                         // Sign extended
        if (!acc_clear) acc_next = acc + s1_sum;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_clear <= 1'b1;
            acc_last  <= 1'b0;
            acc_final <= 1'b0;
            res_valid <= 1'b0;
            res_final <= 1'b0;
        end else begin
            if (s1_valid) acc_clear <= s1_last;
            acc_last  <= s1_valid && s1_last;
            acc_final <= s1_valid && s1_final;
            res_valid <= acc_last;                 // One cycle after last chunk
            res_final <= acc_last && acc_final;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) acc <= acc_next;
        if (acc_last) res_data <= saturate(acc);   // Held until next result
    end

endmodule

// File: mm_bram.sv
// ------------------------------------------------
// Simple dual-port memory
// Port A byte-masked write, port B registered read
// ------------------------------------------------
`timescale 1ns/10ps

module mm_bram #(
    parameter int  WORD_WIDTH = mm_fix_pkg::DEF_WIDTH * mm_geom_pkg::DEF_CHUNK_SIZE,
    parameter int  DEPTH      = 16,
    localparam int BE_W       = WORD_WIDTH / mm_geom_pkg::BYTE_WIDTH,
    localparam int AW         = mm_geom_pkg::addr_bits(DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Port A, host writes
    input  logic                  wr_en,
    input  logic [BE_W-1:0]       wr_be,
    input  logic [AW-1:0]         wr_addr,
    input  logic [WORD_WIDTH-1:0] wr_data,
    // Port B, controller reads
    input  logic                  rd_en,
    input  logic [AW-1:0]         rd_addr,
    output logic [WORD_WIDTH-1:0] rd_data
);
    import mm_geom_pkg::*;

    logic [WORD_WIDTH-1:0] mem [DEPTH]; // Storage array

    // Only enabled bytes change, others keep old contents
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BE_W; b++) begin
                if (wr_be[b]) begin
                    mem[wr_addr][b*BYTE_WIDTH +: BYTE_WIDTH] <= wr_data[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

    // One cycle read latency, output reg holds between reads
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: mm_fix_pkg.sv
// ------------------------------------------------
// Fixed-point format package
// ------------------------------------------------
package mm_fix_pkg;

    // Signed Q format of operands and results
    localparam int DEF_WIDTH      = 16; // Total element bits
    localparam int DEF_FRAC_WIDTH = 8;  // Fraction bits, Q8 by default

    // Headroom above 2*WIDTH in the accumulator
    // Covers the growth of a sum over the inner dimension
    localparam int ACC_GUARD      = 8;

endpackage

// File: mm_geom_pkg.sv
// ------------------------------------------------
// Matrix geometry package
// Shape defaults, chunk geometry, address helpers
// ------------------------------------------------
package mm_geom_pkg;

    // Chunk geometry
    localparam int DEF_CHUNK_SIZE        = 4;  // Elements per memory word
    localparam int BYTE_WIDTH            = 8;  // Write enable granularity

    // Matrix shape, C = I * W^T
    localparam int DEF_INNER_DIMENSION   = 8;  // Shared dimension K
    localparam int DEF_I_OUTER_DIMENSION = 3;  // Rows of I and of C
    localparam int DEF_W_OUTER_DIMENSION = 2;  // Rows of W, columns of C

    // Address width for a memory of the given word count
    // Never below one bit, so single-word memories still get a port
    function automatic int addr_bits(input int words);
        return (words > 1) ? $clog2(words) : 1;
    endfunction

endpackage
